// ==== files.f ====
logic/useq_pkg.sv
logic/cycle_fsm.sv
logic/upc_counter.sv
logic/spc_stack.sv
logic/micro_sequencer.sv
tb/micro_sequencer_props.sv
tb/micro_sequencer_tb.sv

// ==== logic/cycle_fsm.sv ====
// Machine cycle controller
module cycle_fsm (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            run,
   input  useq_pkg::uinst_t                uinst,
   output useq_pkg::phase_t                phase,
   output logic                            fetch,
   output logic                            srp,
   output logic                            swp,
   output logic                            spcnt,
   output logic                            spush,
   output useq_pkg::next_sel_t             next_sel,
   output logic [useq_pkg::upc_width-1:0]  target,
   output logic [useq_pkg::tag_width-1:0]  tag
);
   import useq_pkg::*;

   phase_t phase_next;
   logic   decode_edge;
   logic   is_call;
   logic   is_ret;

   // Fixed rotation through the four phases
   always_comb begin
      case (phase)
         ph_decode:  phase_next = ph_execute;
         ph_execute: phase_next = ph_write;
         ph_write:   phase_next = ph_fetch;
         default:    phase_next = ph_decode;
      endcase
   end

   // Phase only moves while run is high
   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= ph_decode;
      end else if (run) begin
         phase <= phase_next;
      end
   end

   // Instruction is taken on the edge leaving decode
   assign decode_edge = run && (phase == ph_decode);
   assign is_call     = (uinst.op == uop_call);
   assign is_ret      = (uinst.op == uop_ret);

   // Strobes and levels
   // srp is high through execute, swp through write, fetch through fetch
   always_ff @(posedge clk) begin
      if (reset) begin
         srp      <= 1'b0;
         swp      <= 1'b0;
         fetch    <= 1'b0;
         spcnt    <= 1'b0;
         spush    <= 1'b0;
         next_sel <= sel_inc;
      end else begin
         srp   <= decode_edge && is_ret;
         // spush doubles as the latched call flag
         swp   <= run && (phase == ph_execute) && spush;
         fetch <= run && (phase == ph_write);
         if (decode_edge) begin
            // Pointer moves for call and return only
            spcnt <= is_call || is_ret;
            spush <= is_call;
            case (uinst.op)
               uop_jump: next_sel <= sel_target;
               uop_call: next_sel <= sel_target;
               uop_ret:  next_sel <= sel_stack;
               default:  next_sel <= sel_inc;
            endcase
         end
      end
   end

   // Jump or call target and the tag saved by a call
   always_ff @(posedge clk) begin
      if (decode_edge) begin
         target <= uinst.target;
         tag    <= uinst.tag;
      end
   end

endmodule

// ==== logic/micro_sequencer.sv ====
// Micro sequencer top level
module micro_sequencer (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                run,
   input  useq_pkg::uinst_t                    uinst,
   output logic [useq_pkg::upc_width-1:0]      upc,
   output logic                                fetch,
   output logic [useq_pkg::spc_ptr_width-1:0]  spc_ptr,
   output logic [useq_pkg::tag_width-1:0]      ret_tag
);
   import useq_pkg::*;

   // Controller outputs
   logic                 srp;
   logic                 swp;
   logic                 spcnt;
   logic                 spush;
   next_sel_t            next_sel;
   logic [upc_width-1:0] target;
   logic [tag_width-1:0] tag;

   // Datapath between counter and stack
   logic [upc_width-1:0] upc_next_seq;
   spc_word_t            spcw;
   spc_word_t            spco;

   // Cycle controller
   cycle_fsm u_cycle_fsm (
      .clk      (clk),
      .reset    (reset),
      .run      (run),
      .uinst    (uinst),
      .phase    (),
      .fetch    (fetch),
      .srp      (srp),
      .swp      (swp),
      .spcnt    (spcnt),
      .spush    (spush),
      .next_sel (next_sel),
      .target   (target),
      .tag      (tag)
   );

   // Micro PC
   upc_counter u_upc_counter (
      .clk          (clk),
      .reset        (reset),
      .fetch        (fetch),
      .next_sel     (next_sel),
      .target       (target),
      .spco         (spco),
      .upc          (upc),
      .upc_next_seq (upc_next_seq)
   );

   // Pushed entry is the call tag and the return address
   assign spcw.tag = tag;
   assign spcw.pc  = upc_next_seq;

   // Return stack
   spc_stack u_spc_stack (
      .clk    (clk),
      .reset  (reset),
      .fetch  (fetch),
      .spcnt  (spcnt),
      .spush  (spush),
      .srp    (srp),
      .swp    (swp),
      .spcw   (spcw),
      .spco   (spco),
      .spcptr (spc_ptr)
   );

   // Tag of the last popped entry
   assign ret_tag = spco.tag;

endmodule

// ==== logic/spc_stack.sv ====
// Subroutine return stack
module spc_stack (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                fetch,
   input  logic                                spcnt,
   input  logic                                spush,
   input  logic                                srp,
   input  logic                                swp,
   input  useq_pkg::spc_word_t                 spcw,
   output useq_pkg::spc_word_t                 spco,
   output logic [useq_pkg::spc_ptr_width-1:0]  spcptr
);
   import useq_pkg::*;

   spc_word_t                mem [spc_depth];
   logic [spc_ptr_width-1:0] spcptr_p1;
   logic [spc_ptr_width-1:0] spcadr;
   logic                     rd_hit;

   // Pointer plus one, wraps at the top
   assign spcptr_p1 = spcptr + spc_ptr_width'(1);

   // Push writes above the top, anything else writes at the top
   assign spcadr = (spcnt && spush) ? spcptr_p1 : spcptr;

   // Read and write to the same slot in one cycle
   assign rd_hit = swp && (spcadr == spcptr);

   // Write port
   always_ff @(posedge clk) begin
      if (swp) begin
         mem[spcadr] <= spcw;
      end
   end

   // Registered read port at the pointer
   // Collision returns the new data
   always_ff @(posedge clk) begin
      if (reset) begin
         spco <= '0;
      end else if (srp) begin
         if (rd_hit) begin
            spco <= spcw;
         end else begin
            spco <= mem[spcptr];
         end
      end
   end

   // Stack pointer
   // Moves once per instruction, on the fetch edge
   // No overflow or underflow check, wraps modulo depth
   always_ff @(posedge clk) begin
      if (reset) begin
         spcptr <= '0;
      end else if (fetch && spcnt) begin
         if (spush) begin
            spcptr <= spcptr_p1;
         end else begin
            spcptr <= spcptr - spc_ptr_width'(1);
         end
      end
   end

endmodule

// ==== logic/upc_counter.sv ====
// Micro PC counter
module upc_counter (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            fetch,
   input  useq_pkg::next_sel_t             next_sel,
   input  logic [useq_pkg::upc_width-1:0]  target,
   input  useq_pkg::spc_word_t             spco,
   output logic [useq_pkg::upc_width-1:0]  upc,
   output logic [useq_pkg::upc_width-1:0]  upc_next_seq
);
   import useq_pkg::*;

   logic [upc_width-1:0] upc_next;

   // Sequential successor
   // Also the return address pushed by a call
   assign upc_next_seq = upc + upc_width'(1);

   // Next address mux
   always_comb begin
      case (next_sel)
         sel_inc: begin
            upc_next = upc_next_seq;
         end
         sel_target: begin
            // Jump and call both land on the target
            upc_next = target;
         end
         sel_stack: begin
            // Return address popped in execute, valid by write
            upc_next = spco.pc;
         end
         default: begin
            // Unused select code keeps the current address
            upc_next = upc;
         end
      endcase
   end

   // Micro PC register
   // Loads only on the fetch edge, holds through the other phases
   always_ff @(posedge clk) begin
      if (reset) begin
         upc <= '0;
      end else if (fetch) begin
         upc <= upc_next;
      end
   end

endmodule

// ==== logic/useq_pkg.sv ====
// Micro sequencer shared types
package useq_pkg;

   // Micro PC and call tag widths
   localparam int upc_width = 14;
   localparam int tag_width = 5;

   // Return stack geometry
   localparam int spc_depth     = 32;
   localparam int spc_ptr_width = 5;

   // Microinstruction operation
   typedef enum logic [1:0] {
      uop_step = 2'd0,
      uop_jump = 2'd1,
      uop_call = 2'd2,
      uop_ret  = 2'd3
   } uop_t;

   // Four phases of one machine cycle
   typedef enum logic [1:0] {
      ph_decode  = 2'd0,
      ph_execute = 2'd1,
      ph_write   = 2'd2,
      ph_fetch   = 2'd3
   } phase_t;

   // Source of the next micro PC
   // Encoding 3 is unused
   typedef enum logic [1:0] {
      sel_inc    = 2'd0,
      sel_target = 2'd1,
      sel_stack  = 2'd2
   } next_sel_t;

   // Microinstruction as supplied from outside, 21 bits
   typedef struct packed {
      uop_t                 op;
      logic [tag_width-1:0] tag;
      logic [upc_width-1:0] target;
   } uinst_t;

   // Return stack entry, 19 bits
   // Tag in the upper bits, return address below
   typedef struct packed {
      logic [tag_width-1:0] tag;
      logic [upc_width-1:0] pc;
   } spc_word_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the micro sequencer simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module micro_sequencer_tb -f files.f > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vmicro_sequencer_tb > sim.log 2>&1 \
   || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

// ==== tb/micro_sequencer_props.sv ====
// Sequencer timing assertions
module micro_sequencer_props (
   input logic                                clk,
   input logic                                reset,
   input logic                                run,
   input logic                                fetch,
   input logic                                srp,
   input logic                                swp,
   input logic [useq_pkg::spc_ptr_width-1:0]  spc_ptr
);
   timeunit 1ns;
   timeprecision 1ps;
   import useq_pkg::*;

   // Next fetch four cycles on, when run stayed high all the way
   fetch_period: assert property (@(posedge clk) disable iff (reset)
      $past(fetch, 4) && $past(run, 4) && $past(run, 3) && $past(run, 2) && $past(run, 1)
      |-> fetch)
      else $error("fetch pulse missing four cycles after the previous one");

   // A full rotation separates two fetch pulses
   fetch_gap: assert property (@(posedge clk) disable iff (reset)
      fetch |-> !$past(fetch, 1) && !$past(fetch, 2) && !$past(fetch, 3))
      else $error("fetch pulses closer than four cycles");

   // Read and write strobes are exclusive
   strobe_excl: assert property (@(posedge clk) disable iff (reset)
      !(srp && swp))
      else $error("srp and swp high together");

   // Pointer moves one step, right after a fetch
   ptr_motion: assert property (@(posedge clk) disable iff (reset)
      !$stable(spc_ptr) |-> $past(fetch)
         && (spc_ptr == spc_ptr_width'($past(spc_ptr) + 1)
            || spc_ptr == spc_ptr_width'($past(spc_ptr) - 1)))
      else $error("stack pointer moved outside a fetch edge or by more than one");

endmodule

bind micro_sequencer micro_sequencer_props u_props (
   .clk     (clk),
   .reset   (reset),
   .run     (run),
   .fetch   (fetch),
   .srp     (srp),
   .swp     (swp),
   .spc_ptr (spc_ptr)
);

// ==== tb/micro_sequencer_tb.sv ====
// Micro sequencer testbench
module micro_sequencer_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import useq_pkg::*;

   localparam int clk_period   = 4;
   localparam int reset_cycles = 16;
   // Longest wait for one fetch pulse
   localparam int fetch_wait   = 12;
   // Instructions issued by each test
   localparam int step_insts   = 6;
   localparam int jump_rounds  = 3;
   localparam int jump_insts   = 2 * jump_rounds;
   localparam int call_insts   = 3;
   localparam int nest_depth   = 8;
   localparam int nest_insts   = 4 * nest_depth;
   localparam int total_insts  = step_insts + jump_insts + call_insts + nest_insts;
   // Pauses and idle gaps fit inside the margin
   localparam int margin_cycles   = 120;
   localparam int watchdog_cycles = reset_cycles + 4 * total_insts + margin_cycles;

   logic                     clk;
   logic                     reset;
   logic                     run;
   uinst_t                   uinst;
   logic [upc_width-1:0]     upc;
   logic                     fetch;
   logic [spc_ptr_width-1:0] spc_ptr;
   logic [tag_width-1:0]     ret_tag;

   integer seed;
   int     upc_errors;
   int     ptr_errors;
   int     tag_errors;
   int     other_errors;

   // Reference state
   logic [upc_width-1:0]     exp_upc;
   logic [spc_ptr_width-1:0] exp_ptr;
   spc_word_t                model_stack[$];

   micro_sequencer dut (
      .clk     (clk),
      .reset   (reset),
      .run     (run),
      .uinst   (uinst),
      .upc     (upc),
      .fetch   (fetch),
      .spc_ptr (spc_ptr),
      .ret_tag (ret_tag)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic check_upc(input logic [upc_width-1:0] actual,
                            input logic [upc_width-1:0] expected, input string what);
      if (actual !== expected) begin
         upc_errors = upc_errors + 1;
         $display("CHECK FAILED at %0d ns: %s, upc 0x%h, expected 0x%h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic check_ptr(input logic [spc_ptr_width-1:0] actual,
                            input logic [spc_ptr_width-1:0] expected, input string what);
      if (actual !== expected) begin
         ptr_errors = ptr_errors + 1;
         $display("CHECK FAILED at %0d ns: %s, spc_ptr %0d, expected %0d",
                  $time, what, actual, expected);
      end
   endtask

   task automatic check_tag(input logic [tag_width-1:0] actual,
                            input logic [tag_width-1:0] expected, input string what);
      if (actual !== expected) begin
         tag_errors = tag_errors + 1;
         $display("CHECK FAILED at %0d ns: %s, ret_tag 0x%h, expected 0x%h",
                  $time, what, actual, expected);
      end
   endtask

   function automatic logic [upc_width-1:0] rand_upc();
      logic [31:0] r;
      r = $random(seed);
      return r[upc_width-1:0];
   endfunction

   function automatic logic [tag_width-1:0] rand_tag();
      logic [31:0] r;
      r = $random(seed);
      return r[tag_width-1:0];
   endfunction

   // Put one instruction in front of the decode edge
   task automatic present_inst(input uop_t op_code, input logic [tag_width-1:0] call_tag,
                               input logic [upc_width-1:0] dest);
      uinst.op     = op_code;
      uinst.tag    = call_tag;
      uinst.target = dest;
      run          = 1'b1;
   endtask

   // Returns on the falling edge after the fetch edge, back in decode
   task automatic wait_fetch();
      int waited;
      waited = 0;
      @(negedge clk);
      while (fetch !== 1'b1 && waited < fetch_wait) begin
         @(negedge clk);
         waited = waited + 1;
      end
      if (fetch !== 1'b1) begin
         other_errors = other_errors + 1;
         $display("No fetch pulse within %0d cycles, stopped waiting at %0d ns",
                  fetch_wait, $time);
      end else begin
         @(negedge clk);
      end
   endtask

   // Run low, nothing may move
   task automatic pause_run(input int cycles);
      run = 1'b0;
      repeat (cycles) begin
         @(negedge clk);
         if (fetch !== 1'b0) begin
            other_errors = other_errors + 1;
            $display("Fetch pulse seen while run is low at %0d ns", $time);
         end
         check_upc(upc, exp_upc, "upc moved while paused");
      end
   endtask

   task automatic step_inst();
      present_inst(uop_step, rand_tag(), rand_upc());
      wait_fetch();
      exp_upc = exp_upc + 1'b1;
      check_upc(upc, exp_upc, "step");
      check_ptr(spc_ptr, exp_ptr, "step");
   endtask

   task automatic jump_inst(input logic [upc_width-1:0] dest);
      present_inst(uop_jump, rand_tag(), dest);
      wait_fetch();
      exp_upc = dest;
      check_upc(upc, exp_upc, "jump");
      check_ptr(spc_ptr, exp_ptr, "jump");
   endtask

   // Model pushes tag and return address
   task automatic call_inst(input logic [tag_width-1:0] call_tag,
                            input logic [upc_width-1:0] dest);
      spc_word_t entry;
      entry.tag = call_tag;
      entry.pc  = exp_upc + 1'b1;
      model_stack.push_back(entry);
      present_inst(uop_call, call_tag, dest);
      wait_fetch();
      exp_upc = dest;
      exp_ptr = exp_ptr + 1'b1;
      check_upc(upc, exp_upc, "call");
      check_ptr(spc_ptr, exp_ptr, "call");
   endtask

   task automatic return_inst();
      spc_word_t entry;
      entry = model_stack.pop_back();
      present_inst(uop_ret, rand_tag(), rand_upc());
      wait_fetch();
      exp_upc = entry.pc;
      exp_ptr = exp_ptr - 1'b1;
      check_upc(upc, exp_upc, "return");
      check_ptr(spc_ptr, exp_ptr, "return");
      check_tag(ret_tag, entry.tag, "return");
   endtask

   task automatic after_reset();
      check_upc(upc, '0, "after reset");
      check_ptr(spc_ptr, '0, "after reset");
      check_tag(ret_tag, '0, "after reset");
      pause_run(12);
   endtask

   task automatic step_and_pause();
      repeat (4) step_inst();
      // Pause in the middle of an instruction
      present_inst(uop_step, rand_tag(), rand_upc());
      @(negedge clk);
      pause_run(6);
      run = 1'b1;
      wait_fetch();
      exp_upc = exp_upc + 1'b1;
      check_upc(upc, exp_upc, "step resumed after pause");
      // Pause between two instructions
      pause_run(5);
      step_inst();
   endtask

   task automatic jump_targets();
      repeat (jump_rounds) begin
         jump_inst(rand_upc());
         step_inst();
      end
   endtask

   task automatic call_then_return();
      logic [upc_width-1:0]     caller_upc;
      logic [spc_ptr_width-1:0] caller_ptr;
      caller_upc = exp_upc;
      caller_ptr = exp_ptr;
      call_inst(rand_tag(), rand_upc());
      step_inst();
      return_inst();
      check_upc(upc, caller_upc + 1'b1, "return to caller");
      check_ptr(spc_ptr, caller_ptr, "pointer after return");
   endtask

   task automatic nested_calls();
      logic [spc_ptr_width-1:0] start_ptr;
      start_ptr = exp_ptr;
      repeat (nest_depth) begin
         call_inst(rand_tag(), rand_upc());
         step_inst();
      end
      // Unwind in LIFO order
      repeat (nest_depth) begin
         return_inst();
         step_inst();
      end
      check_ptr(spc_ptr, start_ptr, "pointer after nested returns");
   endtask

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      run          = 1'b0;
      uinst        = '0;
      seed         = 32'h9636_6cf7;
      upc_errors   = 0;
      ptr_errors   = 0;
      tag_errors   = 0;
      other_errors = 0;
      exp_upc      = '0;
      exp_ptr      = '0;
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      after_reset();
      step_and_pause();
      pause_run(3);
      jump_targets();
      pause_run(3);
      call_then_return();
      pause_run(3);
      nested_calls();
      pause_run(3);
      $display("Errors: upc %0d, pointer %0d, tag %0d, other %0d",
               upc_errors, ptr_errors, tag_errors, other_errors);
      if (upc_errors + ptr_errors + tag_errors + other_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(watchdog_cycles * clk_period);
      $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule
